/* ks10Mem.f */
rtl/ks10BusPkg.sv
rtl/memPkg.sv
rtl/memReqIf.sv
rtl/busDecode.sv
rtl/memStat.sv
rtl/ssramCtrl.sv
rtl/ks10Mem.sv
sim/ssramModel.sv
sim/ks10Mem_sva.sv
sim/ks10MemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ks10Mem.f --top-module ks10MemTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/Vks10MemTb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi

exit 0

/* sim/ks10MemTb.sv */
// Directed testbench for the KS10 memory controller. Inputs change on the falling edge,
// outputs are sampled settleDly later in the low phase. Stops at the first error.

`default_nettype none

module ks10MemTb
   import ks10BusPkg::*;
   import memPkg::*;
();

   localparam int clkPeriod   = 10;
   localparam int settleDly   = 2;     // Sample point after the falling edge
   localparam int resetCycles = 10;
   localparam int ackLimit    = 10;    // Cycles allowed for busAck
   localparam int numTests    = 5;
   localparam int numWrites   = 20;

   logic       clk = 1'b0;
   logic       rst = 1'b1;
   logic       busReq = 1'b0;
   busWord_t   busAddrIn = '0;
   busWord_t   busDataIn = '0;
   busWord_t   ssramDataIn;
   logic       busAck;
   busWord_t   busDataOut;
   logic       ssramCe;
   logic       ssramWeN;
   ssramAddr_t ssramAddr;
   busWord_t   ssramDataOut;
   logic       ssramDataOe;

   always #(clkPeriod / 2) clk = ~clk;

   ks10Mem ks10Mem_i
   (
      .clk          (clk),
      .rst          (rst),
      .busReq       (busReq),
      .busAddrIn    (busAddrIn),
      .busDataIn    (busDataIn),
      .ssramDataIn  (ssramDataIn),
      .busAck       (busAck),
      .busDataOut   (busDataOut),
      .ssramCe      (ssramCe),
      .ssramWeN     (ssramWeN),
      .ssramAddr    (ssramAddr),
      .ssramDataOut (ssramDataOut),
      .ssramDataOe  (ssramDataOe)
   );

   ssramModel ssram_i
   (
      .clk    (clk),
      .ce     (ssramCe),
      .weN    (ssramWeN),
      .addr   (ssramAddr),
      .wrData (ssramDataOut),
      .rdData (ssramDataIn)
   );

   //////////////////////////////////////////////////
   // Compare tasks and word builders
   //////////////////////////////////////////////////

   task automatic compareWord(input busWord_t got, input busWord_t exp, input string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %012o expected %012o", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic compareAck(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, busAck %b expected %b", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   // Physical memory request, address in bits 16 to 35
   function automatic busWord_t memWord(input int flagBit, input ssramAddr_t addr);
      busWord_t w;
      w          = '0;
      w[flagBit] = 1'b1;
      w[bitPhys] = 1'b1;
      w[16:35]   = addr;
      return w;
   endfunction

   // Physical IO request, device in 14..17, IO address in 18..35
   function automatic busWord_t ioWord(input int flagBit, input busDev_t dev,
                                       input busIoAddr_t ioAddr);
      busWord_t w;
      w          = '0;
      w[flagBit] = 1'b1;
      w[bitPhys] = 1'b1;
      w[bitIo]   = 1'b1;
      w[14:17]   = dev;
      w[18:35]   = ioAddr;
      return w;
   endfunction

   function automatic busWord_t randWord();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[35:0];
   endfunction

   //////////////////////////////////////////////////
   // Bus access tasks
   //////////////////////////////////////////////////

   // Hold the request until busAck, drop it after the edge that takes the ack
   task automatic busCycle(input busWord_t addrWord, input busWord_t dataIn,
                           output busWord_t dataOut);
      int   waitCnt;
      logic acked;
      waitCnt = 0;
      acked   = 1'b0;
      dataOut = '0;
      @(negedge clk);
      busReq    = 1'b1;
      busAddrIn = addrWord;
      busDataIn = dataIn;
      while (!acked && waitCnt < ackLimit)
      begin
         #settleDly;
         if (busAck)
         begin
            acked   = 1'b1;
            dataOut = busDataOut;   // Valid in the ack cycle
         end
         else
         begin
            waitCnt++;
            @(negedge clk);
         end
      end
      if (!acked)
      begin
         $display("No acknowledge within %0d cycles for address word %012o", ackLimit, addrWord);
         $display("TEST FAILED");
         $fatal(1, "bus access timed out");
      end
      else
      begin
         @(posedge clk);
         @(negedge clk);
         busReq = 1'b0;
      end
   endtask

   task automatic busRead(input busWord_t addrWord, output busWord_t data);
      busCycle(addrWord, '0, data);
   endtask

   task automatic busWrite(input busWord_t addrWord, input busWord_t data);
      busWord_t ignored;
      busCycle(addrWord, data, ignored);
   endtask

   // Request that must stay unanswered
   task automatic noAckRequest(input busWord_t addrWord, input string what);
      @(negedge clk);
      busReq    = 1'b1;
      busAddrIn = addrWord;
      repeat (ackLimit)
      begin
         #settleDly;
         compareAck(busAck, 1'b0, what);
         @(negedge clk);
      end
      busReq = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic msrAccess();
      busWord_t  data;
      busWord_t  exp;
      msrForce_t forcePat;
      forcePat = 7'b1010011;
      exp = '0;
      exp[msrPwrFail] = 1'b1;   // Only power fail after reset
      busRead(ioWord(bitRead, memDev, addrMsr), data);
      compareWord(data, exp, "MSR after reset");
      exp = '0;
      exp[msrPwrFail] = 1'b1;   // Write one to clear
      exp[msrEccDis] = 1'b1;
      exp[msrForceFirst:msrForceLast] = forcePat;
      busWrite(ioWord(bitWrite, memDev, addrMsr), exp);
      exp[msrPwrFail] = 1'b0;
      busRead(ioWord(bitRead, memDev, addrMsr), data);
      compareWord(data, exp, "MSR after write");
   endtask

   task automatic randomMemory();
      ssramAddr_t  addrList [numWrites];
      busWord_t    refMem [ssramAddr_t];   // Last value written per address
      busWord_t    data;
      logic [31:0] rnd;
      for (int i = 0; i < numWrites; i++)
      begin
         rnd = $urandom;
         addrList[i] = rnd[19:0];
         data = randWord();
         refMem[addrList[i]] = data;
         busWrite(memWord(bitWrite, addrList[i]), data);
      end
      for (int i = 0; i < numWrites; i++)
      begin
         busRead(memWord(bitRead, addrList[i]), data);
         compareWord(data, refMem[addrList[i]], "memory read back");
      end
   endtask

   task automatic writeTestRead();
      busWord_t data;
      busWrite(memWord(bitWrite, 20'h5A5A5), 36'o707070123456);
      busRead(memWord(bitWrTest, 20'h5A5A5), data);
      compareWord(data, 36'o707070123456, "write-test data");
      busRead(memWord(bitRead, 20'h5A5A5), data);
      compareWord(data, 36'o707070123456, "read after write-test");
   endtask

   task automatic unackedIo();
      noAckRequest(ioWord(bitRead, 4'd1, addrMsr), "IO read to device 1");
      noAckRequest(ioWord(bitRead, memDev, 18'o100001), "IO read to other address");
   endtask

   // Same device and address fields as the MSR, IO flag clear
   task automatic ioFlagSource();
      busWord_t data;
      busWrite(memWord(bitWrite, {2'b00, addrMsr}), 36'o123456701234);
      busRead(memWord(bitRead, {2'b00, addrMsr}), data);
      compareWord(data, 36'o123456701234, "memory read at MSR offset");
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial
   begin
      repeat (numTests * 200 + resetCycles) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("TEST FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin
      void'($urandom(13290));
      repeat (resetCycles) @(negedge clk);
      rst = 1'b0;
      msrAccess();
      randomMemory();
      writeTestRead();
      unackedIo();
      ioFlagSource();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/ks10Mem_sva.sv */
// Bus and SSRAM strobe checks, bound into the controller top.

`default_nettype none

module ks10MemSva
(
   input wire clk,
   input wire rst,
   input wire busReq,
   input wire busAck,
   input wire ssramCe,
   input wire ssramWeN,
   input wire ssramDataOe
);

   // Acknowledge only answers a held request
   ackHasReq: assert property (@(posedge clk) disable iff (rst) busAck |-> busReq)
      else $error("busAck high while busReq is low");

   // Master drops the request once acknowledged
   reqDropped: assert property (@(posedge clk) disable iff (rst) busAck |=> !busReq)
      else $error("busReq still high the cycle after busAck");

   // Write strobe only in the first chip enable cycle, with data drive
   weHasOeCe: assert property (@(posedge clk) disable iff (rst)
      !ssramWeN |-> (ssramDataOe && ssramCe && $rose(ssramCe)))
      else $error("ssramWeN low outside the first ssramCe cycle or without ssramDataOe");

   oeOneCycle: assert property (@(posedge clk) disable iff (rst) ssramDataOe |=> !ssramDataOe)
      else $error("ssramDataOe high for two cycles");

endmodule

bind ks10Mem ks10MemSva ks10MemSva_i
(
   .clk         (clk),
   .rst         (rst),
   .busReq      (busReq),
   .busAck      (busAck),
   .ssramCe     (ssramCe),
   .ssramWeN    (ssramWeN),
   .ssramDataOe (ssramDataOe)
);

`default_nettype wire

/* sim/ssramModel.sv */
// Behavioral synchronous SRAM, 1M x 36, one-cycle registered read.
// No initial contents; unwritten words read as whatever the simulator starts with.

`default_nettype none

module ssramModel
   import ks10BusPkg::*;
   import memPkg::*;
(
   input  wire clk,
   input  wire ce,                  // Chip enable
   input  wire weN,                 // Write enable, active low
   input  wire ssramAddr_t addr,    // Word address
   input  wire busWord_t wrData,    // Data from controller
   output busWord_t rdData          // Registered read data
);

   busWord_t mem [0:(1 << 20) - 1];

   always_ff @(posedge clk)
   begin
      if (ce)
      begin
         if (!weN)
            mem[addr] <= wrData;   // Store at edge ending T2
         rdData <= mem[addr];      // Old word on a write edge
      end
   end

endmodule

`default_nettype wire

/* rtl/ks10Mem.sv */
// KS10 memory controller top, single clock. SSRAM data bus split into in, out and enable.
// busAck is a strobe; the master drops busReq after seeing it.

`default_nettype none

module ks10Mem
   import ks10BusPkg::*;
   import memPkg::*;
(
   input  wire clk,
   input  wire rst,
   input  wire busReq,                  // Bus request level
   input  wire busWord_t busAddrIn,     // Flags and address
   input  wire busWord_t busDataIn,     // Bus write data
   input  wire busWord_t ssramDataIn,   // SSRAM read data
   output logic busAck,                 // Bus acknowledge
   output busWord_t busDataOut,         // Bus read data
   output logic ssramCe,                // SSRAM chip enable
   output logic ssramWeN,               // SSRAM write enable, low active
   output ssramAddr_t ssramAddr,        // SSRAM address
   output busWord_t ssramDataOut,       // SSRAM write data
   output logic ssramDataOe             // SSRAM data drive enable
);

   ////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////

   logic     msrRead;
   logic     msrWrite;
   logic     memAck;
   busWord_t regStat;
   busWord_t rdData;

   memReqIf memReq();

   busDecode busDecode_i
   (
      .busReq    (busReq),
      .busAddrIn (busAddrIn),
      .busDataIn (busDataIn),
      .msrRead   (msrRead),
      .msrWrite  (msrWrite),
      .req       (memReq.decode)
   );

   // Status register, device 0
   memStat memStat_i
   (
      .clk       (clk),
      .rst       (rst),
      .msrWrite  (msrWrite),
      .busDataIn (busDataIn),
      .regStat   (regStat)
   );

   ////////////////////////////////////////////////////
   // SSRAM control
   ////////////////////////////////////////////////////

   ssramCtrl ssramCtrl_i
   (
      .clk          (clk),
      .rst          (rst),
      .req          (memReq.ctrl),
      .ssramDataIn  (ssramDataIn),
      .memAck       (memAck),
      .rdData       (rdData),
      .ssramCe      (ssramCe),
      .ssramWeN     (ssramWeN),
      .ssramAddr    (ssramAddr),
      .ssramDataOut (ssramDataOut),
      .ssramDataOe  (ssramDataOe)
   );

   // IO flag alone picks the source
   assign busDataOut = busAddrIn[bitIo] ? regStat : rdData;

   // MSR acks in the request cycle, memory at T4
   assign busAck = msrRead | msrWrite | memAck;

endmodule

`default_nettype wire

/* rtl/ssramCtrl.sv */
// SSRAM sequencer on a free-running T1..T4 cycle. Request must be held until memAck.
// Write-test runs as a read. No back-pressure; a request held past T4 restarts at T1.

`default_nettype none

module ssramCtrl
   import ks10BusPkg::*;
   import memPkg::*;
(
   input  wire clk,
   input  wire rst,
   memReqIf.ctrl req,                   // Decoded memory request
   input  wire busWord_t ssramDataIn,   // SSRAM read data
   output logic memAck,                 // Access done, T4
   output busWord_t rdData,             // Read data to bus mux
   output logic ssramCe,                // Chip enable
   output logic ssramWeN,               // Write enable, active low
   output ssramAddr_t ssramAddr,        // Word address
   output busWord_t ssramDataOut,       // Write data
   output logic ssramDataOe             // Drive enable for write data
);

   ////////////////////////////////////////////////////
   // Phase sequencer
   ////////////////////////////////////////////////////

   memPhase_t phase;

   always_ff @(posedge clk)
   begin
      if (rst)
         phase <= T1;
      else
         case (phase)
            T1: phase <= T2;
            T2: phase <= T3;
            T3: phase <= T4;
            T4: phase <= T1;
         endcase
   end

   ////////////////////////////////////////////////////
   // Cycle start and busy flag
   ////////////////////////////////////////////////////

   logic       memReq;      // Any memory access pending
   logic       busy;        // Active cycle, T2 to T4
   logic       isWrite;     // Latched access kind
   ssramAddr_t addrReg;
   busWord_t   dataReg;

   assign memReq = req.memRead | req.memWrite | req.memWrTest;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy    <= 1'b0;
         isWrite <= 1'b0;
      end
      else if (phase == T1)
      begin
         busy    <= memReq;          // Only starts on a T1
         isWrite <= req.memWrite;    // Write-test is not a write
      end
      else if (phase == T4)
         busy <= 1'b0;               // Cycle done
   end

   // Payload captured with the start of the cycle
   always_ff @(posedge clk)
   begin
      if (phase == T1)
      begin
         addrReg <= req.memAddr;
         dataReg <= req.wrData;
      end
   end

   ////////////////////////////////////////////////////
   // SSRAM strobes
   ////////////////////////////////////////////////////

   logic wrPhase;   // Write slot of an active write

   assign wrPhase = busy & isWrite & (phase == T2);

   assign ssramCe      = busy;          // High T2 through T4
   assign ssramWeN     = ~wrPhase;      // Stored at edge ending T2
   assign ssramDataOe  = wrPhase;       // Drive data only with WE
   assign ssramAddr    = addrReg;
   assign ssramDataOut = dataReg;

   // Read data registered by SSRAM at end of T2, valid T3 and T4
   assign rdData = ssramDataIn;
   assign memAck = busy & (phase == T4);

endmodule

`default_nettype wire

/* rtl/memStat.sv */
// Memory Status Register. Error hold is never set without ECC and reads zero.
// Write takes effect at the same edge as the bus acknowledge.

`default_nettype none

module memStat
   import ks10BusPkg::*;
   import memPkg::*;
(
   input  wire clk,
   input  wire rst,
   input  wire msrWrite,            // Decoded MSR write
   input  wire busWord_t busDataIn, // Bus write data
   output busWord_t regStat         // MSR read value
);

   ////////////////////////////////////////////////////
   // Register fields
   ////////////////////////////////////////////////////

   logic      pwrFail;     // Power fail seen
   logic      eccDis;      // ECC disable
   msrForce_t forceChk;    // Force check bits

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pwrFail  <= 1'b1;      // Power-up counts as a power fail
         eccDis   <= 1'b0;
         forceChk <= '0;
      end
      else if (msrWrite)
      begin
         // Write one to clear
         if (busDataIn[msrPwrFail])
            pwrFail <= 1'b0;

         // Plain loads
         eccDis   <= busDataIn[msrEccDis];
         forceChk <= busDataIn[msrForceFirst:msrForceLast];
      end
   end

   ////////////////////////////////////////////////////
   // Read value
   ////////////////////////////////////////////////////

   always_comb
   begin
      regStat                              = '0;    // Unused bits and error hold read zero
      regStat[msrPwrFail]                  = pwrFail;
      regStat[msrEccDis]                   = eccDis;
      regStat[msrForceFirst:msrForceLast]  = forceChk;
   end

endmodule

`default_nettype wire

/* rtl/busDecode.sv */
// Pure combinational decode. Outputs are only valid while busReq is held.

`default_nettype none

module busDecode
   import ks10BusPkg::*;
   import memPkg::*;
(
   input  wire busReq,              // Request level from master
   input  wire busWord_t busAddrIn, // Flags and address
   input  wire busWord_t busDataIn, // Write data
   output logic msrRead,            // MSR read strobe
   output logic msrWrite,           // MSR write strobe
   memReqIf.decode req              // To SSRAM control
);

   ////////////////////////////////////////////////////
   // Flag and field extraction
   ////////////////////////////////////////////////////

   logic       busRead;
   logic       busWrTest;
   logic       busWrite;
   logic       busPhys;
   logic       busIo;
   busDev_t    busDev;
   busIoAddr_t busIoAddr;
   logic       msrSel;

   assign busRead   = busAddrIn[bitRead];
   assign busWrTest = busAddrIn[bitWrTest];
   assign busWrite  = busAddrIn[bitWrite];
   assign busPhys   = busAddrIn[bitPhys];
   assign busIo     = busAddrIn[bitIo];
   assign busDev    = getDev(busAddrIn);
   assign busIoAddr = getIoAddr(busAddrIn);

   ////////////////////////////////////////////////////
   // MSR decode
   ////////////////////////////////////////////////////

   // Physical IO, device 0, MSR address
   assign msrSel = busReq & busIo & busPhys & (busDev == memDev) & (busIoAddr == addrMsr);

   assign msrRead  = msrSel & busRead;
   assign msrWrite = msrSel & busWrite;
   // Other IO addresses fall through unacknowledged

   ////////////////////////////////////////////////////
   // Memory decode
   ////////////////////////////////////////////////////

   // IO flag clear means memory space, phys flag ignored
   assign req.memRead   = busReq & busRead & ~busIo;
   assign req.memWrite  = busReq & busWrite & ~busIo;
   assign req.memWrTest = busReq & busWrTest & ~busIo;

   assign req.memAddr = getMemAddr(busAddrIn);   // Bits 16 to 35
   assign req.wrData  = busDataIn;

endmodule

`default_nettype wire

/* rtl/memReqIf.sv */
// Decoded memory request. Levels follow the bus request, nothing is registered here.

`default_nettype none

interface memReqIf
   import ks10BusPkg::*;
   import memPkg::*;
();

   logic       memRead;     // Memory read
   logic       memWrite;    // Memory write
   logic       memWrTest;   // Write-test, handled as a read
   ssramAddr_t memAddr;     // Word address
   busWord_t   wrData;      // Write data from the bus

   // Decoder side
   modport decode
   (
      output memRead, memWrite, memWrTest,
      output memAddr, wrData
   );

   // SSRAM control side
   modport ctrl
   (
      input memRead, memWrite, memWrTest,
      input memAddr, wrData
   );

endinterface

`default_nettype wire

/* rtl/memPkg.sv */
// Memory controller definitions. MSR bits not listed here read as zero.

`default_nettype none

package memPkg;

   import ks10BusPkg::*;

   ////////////////////////////////////////////////////
   // Device and register addresses
   ////////////////////////////////////////////////////

   localparam busDev_t    memDev  = 4'd0;         // Memory controller is device 0
   localparam busIoAddr_t addrMsr = 18'o100000;   // Memory Status Register

   // SSRAM address is the bus memory address, no translation
   typedef busMemAddr_t ssramAddr_t;

   // Four-phase memory cycle
   typedef enum logic [1:0]
   {
      T1,
      T2,
      T3,
      T4
   } memPhase_t;

   ////////////////////////////////////////////////////
   // MSR field layout
   ////////////////////////////////////////////////////

   localparam int msrErrHold    = 0;     // Error hold, write one to clear
   localparam int msrPwrFail    = 12;    // Power fail, write one to clear
   localparam int msrEccDis     = 13;    // ECC disable
   localparam int msrForceFirst = 29;    // Force check bits
   localparam int msrForceLast  = 35;

   typedef logic [0:6] msrForce_t;

endpackage

`default_nettype wire

/* rtl/ks10BusPkg.sv */
// KS10 backplane bus word layout. Bits numbered 0 (MSB) to 35 (LSB) as in the KS10.
// Only the flags used by the memory controller are defined here.

`default_nettype none

package ks10BusPkg;

   ////////////////////////////////////////////////////
   // Bus word types
   ////////////////////////////////////////////////////

   typedef logic [0:35] busWord_t;      // Address or data word, big-endian
   typedef logic [0:3]  busDev_t;       // Device number
   typedef logic [0:17] busIoAddr_t;    // IO address within a device
   typedef logic [0:19] busMemAddr_t;   // Physical memory address, 1M words

   ////////////////////////////////////////////////////
   // Flag bits in the address word
   ////////////////////////////////////////////////////

   localparam int bitRead   = 3;        // Read cycle
   localparam int bitWrTest = 4;        // Write-test (read then hold)
   localparam int bitWrite  = 5;        // Write cycle
   localparam int bitPhys   = 8;        // Physical address
   localparam int bitIo     = 10;       // IO space, not memory

   // Field positions in the address word
   localparam int devFirst     = 14;
   localparam int devLast      = 17;
   localparam int ioAddrFirst  = 18;
   localparam int ioAddrLast   = 35;
   localparam int memAddrFirst = 16;
   localparam int memAddrLast  = 35;

   ////////////////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////////////////

   function automatic busDev_t getDev(busWord_t w);
      return w[devFirst:devLast];       // Device, only meaningful in IO space
   endfunction

   function automatic busIoAddr_t getIoAddr(busWord_t w);
      return w[ioAddrFirst:ioAddrLast];
   endfunction

   // Overlaps the device field by two bits
   function automatic busMemAddr_t getMemAddr(busWord_t w);
      return w[memAddrFirst:memAddrLast];
   endfunction

endpackage

`default_nettype wire
